//--- ps_pl_shared_memory.f
logic/axi_lite_pkg.sv
logic/shared_mem_pkg.sv
logic/block_dual_port_ram.sv
logic/axi_lite_ram_slave.sv
logic/ps_pl_shared_memory.sv
verif/ps_pl_shared_memory_assert.sv
verif/ps_pl_shared_memory_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module ps_pl_shared_memory_tb -f ps_pl_shared_memory.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass, see sim.log"; exit 1; }

//--- verif/ps_pl_shared_memory_tb.sv
// testbench for the PS/PL shared memory
// clock and reset, LFSR data, AXI4-Lite host tasks, reference model, directed tests

`timescale 1ns/1ps

module ps_pl_shared_memory_tb;
    import axi_lite_pkg::*;
    import shared_mem_pkg::*;

    // 16 + 9 + 3 + 4 transactions over all tests at 40 cycles each
    localparam int num_transactions = 32;
    localparam int timeout_cycles   = 40 * num_transactions;

    // word used by the strobe and out-of-range tests
    localparam mem_index_t strobe_index = 10'h155;

    logic      clk;
    logic      reset;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    // expected RAM contents
    axi_data_t   model [mem_depth];
    logic [15:0] lfsr_state;
    int          cycle_count;
    int          check_count;
    int          error_count;

    ps_pl_shared_memory i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step for every bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic axi_addr_t word_addr(input mem_index_t idx);
        return axi_addr_t'(idx) << mem_addr_lsb;
    endfunction

    task automatic check_data(input string name, input axi_data_t expected,
                              input axi_data_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t expected,
                              input axi_resp_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // handshake flags
    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("%s: done, %0d errors", name, error_count - start_errors);
    endtask

    // a strobed byte replaces the stored byte and the others stay
    task automatic model_write(input axi_addr_t addr, input axi_data_t data,
                               input axi_strb_t strb);
        mem_index_t idx;
        idx = addr[mem_addr_lsb +: mem_index_width];
        for (int b = 0; b < axi_strb_width; b++)
        begin
            if (strb[b])
            begin
                model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // host tasks are entered right after a rising edge
    task automatic start_write(input axi_addr_t addr, input axi_data_t data,
                               input axi_strb_t strb);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
    endtask

    task automatic accept_write();
        do
            @(posedge clk);
        while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    // bready stays low for hold cycles once bvalid is up
    task automatic finish_write(input string name, input int hold, output axi_resp_t resp);
        axi_resp_t first;
        do
            @(posedge clk);
        while (!bvalid);
        first = bresp;
        repeat (hold)
        begin
            @(posedge clk);
            check_flag({name, " bvalid held"}, 1'b1, bvalid);
            check_resp({name, " bresp stable"}, first, bresp);
            check_flag({name, " no write accepted"}, 1'b0, awready);
        end
        bready <= 1'b1;
        @(posedge clk);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic start_read(input axi_addr_t addr);
        araddr  <= addr;
        arvalid <= 1'b1;
    endtask

    task automatic accept_read();
        do
            @(posedge clk);
        while (!arready);
        arvalid <= 1'b0;
    endtask

    task automatic finish_read(input string name, input int hold,
                               output axi_data_t data, output axi_resp_t resp);
        axi_data_t first_data;
        axi_resp_t first_resp;
        do
            @(posedge clk);
        while (!rvalid);
        first_data = rdata;
        first_resp = rresp;
        repeat (hold)
        begin
            @(posedge clk);
            check_flag({name, " rvalid held"}, 1'b1, rvalid);
            check_data({name, " rdata stable"}, first_data, rdata);
            check_resp({name, " rresp stable"}, first_resp, rresp);
            check_flag({name, " no read accepted"}, 1'b0, arready);
        end
        rready <= 1'b1;
        @(posedge clk);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             input axi_strb_t strb, output axi_resp_t resp);
        start_write(addr, data, strb);
        accept_write();
        // out-of-range writes leave the memory alone
        if (addr < mem_byte_limit)
        begin
            model_write(addr, data, strb);
        end
        finish_write("write", 0, resp);
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                            output axi_resp_t resp);
        start_read(addr);
        accept_read();
        finish_read("read", 0, data, resp);
    endtask

    task automatic reset_test();
        int start;
        start = error_count;
        @(posedge clk);
        check_flag("reset awready", 1'b0, awready);
        check_flag("reset wready", 1'b0, wready);
        check_flag("reset bvalid", 1'b0, bvalid);
        check_flag("reset arready", 1'b0, arready);
        check_flag("reset rvalid", 1'b0, rvalid);
        report_test("reset_test", start);
    endtask

    // full-word writes to random words then read back in the same order
    task automatic write_read_test();
        mem_index_t idx_list [8];
        axi_data_t  data;
        axi_resp_t  resp;
        int         start;
        start = error_count;
        for (int i = 0; i < 8; i++)
        begin
            idx_list[i] = mem_index_t'(random_bits(mem_index_width));
            axi_write(word_addr(idx_list[i]), random_bits(32), 4'hF, resp);
            check_resp("write_read_test bresp", resp_okay, resp);
        end
        for (int i = 0; i < 8; i++)
        begin
            axi_read(word_addr(idx_list[i]), data, resp);
            check_data("write_read_test rdata", model[idx_list[i]], data);
            check_resp("write_read_test rresp", resp_okay, resp);
        end
        report_test("write_read_test", start);
    endtask

    task automatic strobe_test();
        axi_strb_t strobes [4];
        axi_data_t data;
        axi_resp_t resp;
        int        start;
        start   = error_count;
        strobes = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        // known base word first
        axi_write(word_addr(strobe_index), random_bits(32), 4'hF, resp);
        check_resp("strobe_test base bresp", resp_okay, resp);
        for (int i = 0; i < 4; i++)
        begin
            axi_write(word_addr(strobe_index), random_bits(32), strobes[i], resp);
            check_resp("strobe_test bresp", resp_okay, resp);
            axi_read(word_addr(strobe_index), data, resp);
            check_data("strobe_test rdata", model[strobe_index], data);
            check_resp("strobe_test rresp", resp_okay, resp);
        end
        report_test("strobe_test", start);
    endtask

    // the out-of-range address aliases the strobe word in its low bits
    task automatic out_of_range_test();
        axi_addr_t oob_addr;
        axi_data_t data;
        axi_resp_t resp;
        int        start;
        start    = error_count;
        oob_addr = axi_addr_t'(mem_byte_limit) | word_addr(strobe_index);
        axi_write(oob_addr, random_bits(32), 4'hF, resp);
        check_resp("out_of_range_test bresp", resp_slverr, resp);
        axi_read(oob_addr, data, resp);
        check_data("out_of_range_test rdata", '0, data);
        check_resp("out_of_range_test rresp", resp_slverr, resp);
        axi_read(word_addr(strobe_index), data, resp);
        check_data("out_of_range_test alias rdata", model[strobe_index], data);
        check_resp("out_of_range_test alias rresp", resp_okay, resp);
        report_test("out_of_range_test", start);
    endtask

    // a second request waits behind each held response
    task automatic backpressure_test();
        axi_addr_t addr_a;
        axi_addr_t addr_b;
        axi_data_t data_a;
        axi_data_t data_b;
        axi_data_t data;
        axi_resp_t resp;
        int        start;
        start  = error_count;
        addr_a = word_addr(mem_index_t'(random_bits(mem_index_width)));
        addr_b = word_addr(mem_index_t'(random_bits(mem_index_width)));
        data_a = random_bits(32);
        data_b = random_bits(32);
        start_write(addr_a, data_a, 4'hF);
        accept_write();
        model_write(addr_a, data_a, 4'hF);
        start_write(addr_b, data_b, 4'hF);
        finish_write("backpressure_test", 5, resp);
        check_resp("backpressure_test first bresp", resp_okay, resp);
        accept_write();
        model_write(addr_b, data_b, 4'hF);
        finish_write("backpressure_test", 0, resp);
        check_resp("backpressure_test second bresp", resp_okay, resp);
        start_read(addr_a);
        accept_read();
        start_read(addr_b);
        finish_read("backpressure_test", 5, data, resp);
        check_data("backpressure_test first rdata", model[addr_a[mem_addr_lsb +: 10]], data);
        check_resp("backpressure_test first rresp", resp_okay, resp);
        accept_read();
        finish_read("backpressure_test", 0, data, resp);
        check_data("backpressure_test second rdata", model[addr_b[mem_addr_lsb +: 10]], data);
        check_resp("backpressure_test second rresp", resp_okay, resp);
        report_test("backpressure_test", start);
    endtask

    initial
    begin
        reset      = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        lfsr_state = 16'd46575;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        reset_test();
        write_read_test();
        strobe_test();
        out_of_range_test();
        backpressure_test();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verif/ps_pl_shared_memory_assert.sv
// concurrent checks on the AXI4-Lite handshakes of the RAM slave
// bound into axi_lite_ram_slave

`timescale 1ns/1ps

module ps_pl_shared_memory_assert
(
    input logic clk,
    input logic reset,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic arready,
    input logic rvalid,
    input logic rready
);

    // address and data of a write are taken together in one cycle
    awready_wready_paired: assert property (@(posedge clk) disable iff (reset)
        (awready || wready) |-> (awready && wready && awvalid && wvalid))
        else $error("awready and wready not a paired transfer");

    // one read address per acceptance
    arready_single_cycle: assert property (@(posedge clk) disable iff (reset)
        arready |=> !arready)
        else $error("arready high for more than one cycle");

    // responses wait for the host
    bvalid_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    outputs_low_after_reset: assert property (@(posedge clk)
        reset |=> !awready && !wready && !bvalid && !arready && !rvalid)
        else $error("handshake output high after reset");

endmodule

bind axi_lite_ram_slave ps_pl_shared_memory_assert i_assert (.*);

//--- logic/ps_pl_shared_memory.sv
// top of the PS/PL shared memory
// AXI4-Lite slave wired to the block RAM

`timescale 1ns/1ps

module ps_pl_shared_memory
(
    input  logic                     clk,
    input  logic                     reset,
    input  axi_lite_pkg::axi_addr_t  awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  axi_lite_pkg::axi_data_t  wdata,
    input  axi_lite_pkg::axi_strb_t  wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output axi_lite_pkg::axi_resp_t  bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  axi_lite_pkg::axi_addr_t  araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output axi_lite_pkg::axi_data_t  rdata,
    output axi_lite_pkg::axi_resp_t  rresp,
    output logic                     rvalid,
    input  logic                     rready
);
    import axi_lite_pkg::*;
    import shared_mem_pkg::*;

    // slave to RAM
    logic       wr_en;
    mem_index_t wr_index;
    mem_word_t  wr_data;
    axi_strb_t  wr_strb;
    logic       rd_en;
    mem_index_t rd_index;
    mem_word_t  rd_data;

    // host port that decodes addresses and builds responses
    axi_lite_ram_slave i_slave
    (
        .clk      (clk),
        .reset    (reset),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    // 4 KiB of word storage
    block_dual_port_ram i_ram
    (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

endmodule

//--- logic/axi_lite_ram_slave.sv
// AXI4-Lite slave in front of the shared RAM
// write and read channel control, address range check, responses

`timescale 1ns/1ps

module axi_lite_ram_slave
(
    input  logic                        clk,
    input  logic                        reset,

    // write address and write data channels
    input  axi_lite_pkg::axi_addr_t     awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  axi_lite_pkg::axi_data_t     wdata,
    input  axi_lite_pkg::axi_strb_t     wstrb,
    input  logic                        wvalid,
    output logic                        wready,

    // write response channel
    output axi_lite_pkg::axi_resp_t     bresp,
    output logic                        bvalid,
    input  logic                        bready,

    // read address and read data channels
    input  axi_lite_pkg::axi_addr_t     araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output axi_lite_pkg::axi_data_t     rdata,
    output axi_lite_pkg::axi_resp_t     rresp,
    output logic                        rvalid,
    input  logic                        rready,

    // RAM side
    output logic                        wr_en,
    output shared_mem_pkg::mem_index_t  wr_index,
    output shared_mem_pkg::mem_word_t   wr_data,
    output axi_lite_pkg::axi_strb_t     wr_strb,
    output logic                        rd_en,
    output shared_mem_pkg::mem_index_t  rd_index,
    input  shared_mem_pkg::mem_word_t   rd_data
);
    import axi_lite_pkg::*;
    import shared_mem_pkg::*;

    // write channel state
    logic      aw_en;
    axi_addr_t awaddr_q;
    logic      wr_xfer;
    logic      wr_in_range;

    // read channel state
    logic      ar_en;
    axi_addr_t araddr_q;
    logic      reading;
    logic      rd_in_range;

    // aw_en is high while no write is in flight
    // awready and wready pulse together for one cycle once both valids are up
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_en   <= 1'b1;
        end
        else if (awvalid && wvalid && aw_en)
        begin
            awready <= 1'b1;
            wready  <= 1'b1;
            aw_en   <= 1'b0;
        end
        else
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            // next write only after the B transfer
            if (bvalid && bready)
            begin
                aw_en <= 1'b1;
            end
        end
    end

    // capture the write address when the write is accepted
    always_ff @(posedge clk)
    begin
        if (awvalid && wvalid && aw_en)
        begin
            awaddr_q <= awaddr;
        end
    end

    // both channels transfer in the cycle after acceptance
    assign wr_xfer     = awready && awvalid && wready && wvalid;
    assign wr_in_range = awaddr_q < mem_byte_limit;

    // out-of-range writes never reach the RAM
    assign wr_en    = wr_xfer && wr_in_range;
    assign wr_index = awaddr_q[mem_addr_lsb +: mem_index_width];
    assign wr_data  = wdata;
    assign wr_strb  = wstrb;

    // write response raised the cycle after the transfer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bvalid <= 1'b0;
            bresp  <= resp_okay;
        end
        else if (wr_xfer)
        begin
            bvalid <= 1'b1;
            bresp  <= wr_in_range ? resp_okay : resp_slverr;
        end
        else if (bvalid && bready)
        begin
            bvalid <= 1'b0;
        end
    end

    // arready pulse
    // ar_en blocks a second read until the R transfer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            arready <= 1'b0;
            ar_en   <= 1'b1;
        end
        else if (arvalid && ar_en)
        begin
            arready <= 1'b1;
            ar_en   <= 1'b0;
        end
        else
        begin
            arready <= 1'b0;
            if (rvalid && rready)
            begin
                ar_en <= 1'b1;
            end
        end
    end

    // read address latch
    always_ff @(posedge clk)
    begin
        if (arvalid && ar_en)
        begin
            araddr_q <= araddr;
        end
    end

    assign rd_in_range = araddr_q < mem_byte_limit;

    // RAM output register loads on the AR transfer
    assign rd_en    = arready && arvalid;
    assign rd_index = araddr_q[mem_addr_lsb +: mem_index_width];

    // one-cycle reading stage while the RAM word is on rd_data
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reading <= 1'b0;
        end
        else
        begin
            reading <= rd_en;
        end
    end

    // read data and response two cycles after the AR transfer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rvalid <= 1'b0;
            rresp  <= resp_okay;
            rdata  <= '0;
        end
        else if (reading)
        begin
            rvalid <= 1'b1;
            rresp  <= rd_in_range ? resp_okay : resp_slverr;
            // out of range reads back as zero
            rdata  <= rd_in_range ? rd_data : '0;
        end
        else if (rvalid && rready)
        begin
            rvalid <= 1'b0;
        end
    end

endmodule

//--- logic/block_dual_port_ram.sv
// block RAM with a byte-enable write port
// and one registered read port

`timescale 1ns/1ps

module block_dual_port_ram
(
    input  logic                        clk,
    input  logic                        wr_en,
    input  shared_mem_pkg::mem_index_t  wr_index,
    input  shared_mem_pkg::mem_word_t   wr_data,
    input  axi_lite_pkg::axi_strb_t     wr_strb,
    input  logic                        rd_en,
    input  shared_mem_pkg::mem_index_t  rd_index,
    output shared_mem_pkg::mem_word_t   rd_data
);
    import axi_lite_pkg::*;
    import shared_mem_pkg::*;

    // word storage
    mem_word_t mem [mem_depth];

    // write port
    // each strobe bit enables its own byte lane
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int b = 0; b < axi_strb_width; b++)
            begin
                if (wr_strb[b])
                begin
                    mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // read port
    // output register holds its value while rd_en is low
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

//--- logic/shared_mem_pkg.sv
// shared memory geometry
// word index width, byte address split and stored word type

package shared_mem_pkg;

    // 1024 words deep
    localparam int mem_index_width = 10;

    // word index starts above the byte offset bits
    localparam int mem_addr_lsb = 2;

    // number of words held in the RAM
    localparam int mem_depth = 2 ** mem_index_width;

    // first byte address outside the 4 KiB memory
    localparam int unsigned mem_byte_limit = 2 ** (mem_index_width + mem_addr_lsb);

    typedef logic [mem_index_width-1:0] mem_index_t;

    // a stored word is exactly one bus word
    typedef axi_lite_pkg::axi_data_t mem_word_t;

endpackage

//--- logic/axi_lite_pkg.sv
// AXI4-Lite port definitions
// bus widths, payload types and response codes

package axi_lite_pkg;

    // byte address seen on the host port
    localparam int axi_addr_width = 16;

    // one data word per beat
    localparam int axi_data_width = 32;

    // one strobe bit per data byte
    localparam int axi_strb_width = axi_data_width / 8;

    typedef logic [axi_addr_width-1:0] axi_addr_t;
    typedef logic [axi_data_width-1:0] axi_data_t;
    typedef logic [axi_strb_width-1:0] axi_strb_t;
    typedef logic [1:0]                axi_resp_t;

    // bresp and rresp encodings
    localparam axi_resp_t resp_okay   = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

endpackage
